// ==== source/rsa_consts.svh ====
`ifndef RSA_CONSTS_SVH
`define RSA_CONSTS_SVH

// systolic grid size, rows of A by columns of B
`define RSA_X 4
`define RSA_Y 4

// width of one matrix or pose element
`define RSA_DW 32

// width of the drain and row counters
`define RSA_CNT_DW 5

// stage bus, bit 0 predict, bit 1 multiply
`define RSA_STAGE_DW 2

// zero shifts after the last beat
// enough for the last beat to cross the skew and reach the far corner
`define RSA_DRAIN (`RSA_X + `RSA_Y - 1)

`endif

// ==== source/rsa_pkg.sv ====
`include "rsa_consts.svh"

package rsa_pkg;

  // one signed element, wraps modulo 2^32
  typedef logic signed [`RSA_DW-1:0] rsa_data_t;

  // drain and row counter value
  typedef logic [`RSA_CNT_DW-1:0] rsa_cnt_t;

  // one-hot stage request / ready
  typedef logic [`RSA_STAGE_DW-1:0] stage_t;

  // one operand beat: column of A plus row of B
  typedef struct packed {
    rsa_data_t [`RSA_X-1:0] a;
    rsa_data_t [`RSA_Y-1:0] b;
  } op_beat_t;

  // one row of C, lane j is column j
  typedef rsa_data_t [`RSA_Y-1:0] c_row_t;

  // robot pose
  typedef struct packed {
    rsa_data_t x;
    rsa_data_t y;
    rsa_data_t theta;
  } pose_t;

  // increments from the nonlinear unit
  typedef struct packed {
    rsa_data_t d_theta;
    rsa_data_t d_x;
    rsa_data_t d_y;
  } nl_result_t;

  // predicted pose plus the two jacobian terms
  typedef struct packed {
    pose_t     pose_hat;
    rsa_data_t fxi_13;
    rsa_data_t fxi_23;
  } predict_out_t;

  // stage controller phases
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_DRAIN,
    ST_READ,
    ST_RELEASE
  } ctrl_state_t;

endpackage

// ==== source/pe_mac.sv ====
`timescale 1ns/1ps

module pe_mac (
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              i_clear,
  input  logic              i_shift,
  input  rsa_pkg::rsa_data_t i_a,
  input  rsa_pkg::rsa_data_t i_b,
  output rsa_pkg::rsa_data_t o_a,
  output rsa_pkg::rsa_data_t o_b,
  output rsa_pkg::rsa_data_t o_acc
);

  import rsa_pkg::*;

  // product truncated to element width
  rsa_data_t prod;

  assign prod = i_a * i_b;

  // output-stationary cell
  // a moves east, b moves south, sum stays here
  always_ff @(posedge clk) begin
    if (sys_rst || i_clear) begin
      o_acc <= '0;
      o_a   <= '0;
      o_b   <= '0;
    end else if (i_shift) begin
      // accumulate with wrap modulo 2^32
      o_acc <= o_acc + prod;
      // forward operands to the neighbours
      o_a   <= i_a;
      o_b   <= i_b;
    end
  end

endmodule

// ==== source/pe_array.sv ====
`timescale 1ns/1ps
`include "rsa_consts.svh"

module pe_array (
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              i_clear,
  input  logic              i_shift,
  input  logic              i_inject_zero,
  input  rsa_pkg::op_beat_t i_beat,
  input  rsa_pkg::rsa_cnt_t i_row_sel,
  output rsa_pkg::c_row_t   o_row
);

  import rsa_pkg::*;

  // A lanes first, then B lanes
  localparam int NL = `RSA_X + `RSA_Y;

  rsa_data_t lane_in  [NL];
  rsa_data_t lane_out [NL];

  // horizontal and vertical operand links
  rsa_data_t a_h [`RSA_X][`RSA_Y+1];
  rsa_data_t b_v [`RSA_X+1][`RSA_Y];
  rsa_data_t acc [`RSA_X][`RSA_Y];

  genvar k, i, j;

  // zeros flow in while draining
  for (k = 0; k < `RSA_X; k++) begin : g_a_in
    assign lane_in[k] = i_inject_zero ? '0 : i_beat.a[k];
  end
  for (k = 0; k < `RSA_Y; k++) begin : g_b_in
    assign lane_in[`RSA_X + k] = i_inject_zero ? '0 : i_beat.b[k];
  end

  // skew lines
  // row i of A waits i shifts, column j of B waits j shifts
  for (k = 0; k < NL; k++) begin : g_skew
    localparam int D = (k < `RSA_X) ? k : k - `RSA_X;
    if (D == 0) begin : g_direct
      assign lane_out[k] = lane_in[k];
    end else begin : g_line
      rsa_data_t taps [D];
      always_ff @(posedge clk) begin
        if (sys_rst || i_clear) begin
          for (int t = 0; t < D; t++) begin
            taps[t] <= '0;
          end
        end else if (i_shift) begin
          taps[0] <= lane_in[k];
          for (int t = 1; t < D; t++) begin
            taps[t] <= taps[t-1];
          end
        end
      end
      assign lane_out[k] = taps[D-1];
    end
  end

  // grid edges fed from the skew lines
  for (i = 0; i < `RSA_X; i++) begin : g_west
    assign a_h[i][0] = lane_out[i];
  end
  for (j = 0; j < `RSA_Y; j++) begin : g_north
    assign b_v[0][j] = lane_out[`RSA_X + j];
  end

  // cell (i,j) sums A[i][k] * B[k][j]
  for (i = 0; i < `RSA_X; i++) begin : g_row
    for (j = 0; j < `RSA_Y; j++) begin : g_col
      pe_mac u_pe_mac (
        .clk     (clk),
        .sys_rst (sys_rst),
        .i_clear (i_clear),
        .i_shift (i_shift),
        .i_a     (a_h[i][j]),
        .i_b     (b_v[i][j]),
        .o_a     (a_h[i][j+1]),
        .o_b     (b_v[i+1][j]),
        .o_acc   (acc[i][j])
      );
    end
  end

  // row select, out of range reads zero
  always_comb begin
    o_row = '0;
    for (int r = 0; r < `RSA_X; r++) begin
      if (i_row_sel == rsa_cnt_t'(r)) begin
        for (int c = 0; c < `RSA_Y; c++) begin
          o_row[c] = acc[r][c];
        end
      end
    end
  end

endmodule

// ==== source/ekf_predict.sv ====
`timescale 1ns/1ps

module ekf_predict (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  logic                  i_pred_en,
  input  rsa_pkg::pose_t        i_pose,
  input  rsa_pkg::nl_result_t   i_nl,
  output rsa_pkg::predict_out_t o_pred
);

  // motion model step, one cycle
  // values hold between predicts
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_pred <= '0;
    end else if (i_pred_en) begin
      // pose plus increments, wraps modulo 2^32
      o_pred.pose_hat.x     <= i_pose.x + i_nl.d_x;
      o_pred.pose_hat.y     <= i_pose.y + i_nl.d_y;
      o_pred.pose_hat.theta <= i_pose.theta + i_nl.d_theta;
      // jacobian entries w.r.t. theta
      o_pred.fxi_13         <= -i_nl.d_y;
      o_pred.fxi_23         <= i_nl.d_x;
    end
  end

endmodule

// ==== source/stage_ctrl.sv ====
`timescale 1ns/1ps
`include "rsa_consts.svh"

module stage_ctrl (
  input  logic              clk,
  input  logic              sys_rst,
  input  rsa_pkg::stage_t   i_stage_val,
  input  logic              i_op_valid,
  input  logic              i_op_last,
  output rsa_pkg::stage_t   o_stage_rdy,
  output logic              o_pred_en,
  output logic              o_clear,
  output logic              o_shift,
  output logic              o_inject_zero,
  output rsa_pkg::rsa_cnt_t o_row_sel,
  output logic              o_c_valid
);

  import rsa_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  rsa_cnt_t    drain_cnt;
  rsa_cnt_t    row_cnt;
  logic        drain_done;
  logic        last_row;
  logic        beat;

  assign drain_done = (drain_cnt == rsa_cnt_t'(`RSA_DRAIN - 1));
  assign last_row   = (row_cnt == rsa_cnt_t'(`RSA_X - 1));
  // counted operand beat
  assign beat       = (state == ST_LOAD) && i_op_valid;

  // predict has priority over multiply
  assign o_pred_en     = (state == ST_IDLE) && i_stage_val[0];
  assign o_clear       = (state == ST_IDLE) && !i_stage_val[0] && i_stage_val[1];
  // array moves only on beats and drain cycles
  assign o_shift       = beat || (state == ST_DRAIN);
  assign o_inject_zero = (state == ST_DRAIN);
  assign o_c_valid     = (state == ST_READ);
  assign o_row_sel     = row_cnt;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (i_stage_val[0]) begin
          state_nxt = ST_RELEASE;
        end else if (i_stage_val[1]) begin
          state_nxt = ST_LOAD;
        end
      end
      ST_LOAD: begin
        if (beat && i_op_last) begin
          state_nxt = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        if (drain_done) begin
          state_nxt = ST_READ;
        end
      end
      ST_READ: begin
        if (last_row) begin
          state_nxt = ST_RELEASE;
        end
      end
      // wait for the host to drop its request
      ST_RELEASE: begin
        if (i_stage_val == '0) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state       <= ST_IDLE;
      drain_cnt   <= '0;
      row_cnt     <= '0;
      o_stage_rdy <= '0;
    end else begin
      state       <= state_nxt;
      // ready is a single-cycle pulse
      o_stage_rdy <= '0;
      case (state)
        ST_IDLE: begin
          // pose result lands with this pulse
          if (i_stage_val[0]) begin
            o_stage_rdy[0] <= 1'b1;
          end
        end
        ST_LOAD: drain_cnt <= '0;
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          row_cnt   <= '0;
        end
        ST_READ: begin
          row_cnt <= row_cnt + 1'b1;
          // pulse in the cycle after the last row
          if (last_row) begin
            o_stage_rdy[1] <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== source/rsa_top.sv ====
`timescale 1ns/1ps

module rsa_top (
  input  logic                  clk,
  input  logic                  sys_rst,
  input  rsa_pkg::stage_t       i_stage_val,
  input  rsa_pkg::pose_t        i_pose,
  input  rsa_pkg::nl_result_t   i_nl,
  input  rsa_pkg::op_beat_t     i_op,
  input  logic                  i_op_valid,
  input  logic                  i_op_last,
  output rsa_pkg::stage_t       o_stage_rdy,
  output rsa_pkg::predict_out_t o_pred,
  output logic                  o_c_valid,
  output rsa_pkg::rsa_cnt_t     o_c_row_idx,
  output rsa_pkg::c_row_t       o_c_row
);

  import rsa_pkg::*;

  // controller to datapath
  logic     pred_en;
  logic     clear;
  logic     shift;
  logic     inject_zero;
  rsa_cnt_t row_sel;

  // readout index follows the array row select
  assign o_c_row_idx = row_sel;

  stage_ctrl u_stage_ctrl (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_stage_val   (i_stage_val),
    .i_op_valid    (i_op_valid),
    .i_op_last     (i_op_last),
    .o_stage_rdy   (o_stage_rdy),
    .o_pred_en     (pred_en),
    .o_clear       (clear),
    .o_shift       (shift),
    .o_inject_zero (inject_zero),
    .o_row_sel     (row_sel),
    .o_c_valid     (o_c_valid)
  );

  // matrix multiply datapath
  pe_array u_pe_array (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_clear       (clear),
    .i_shift       (shift),
    .i_inject_zero (inject_zero),
    .i_beat        (i_op),
    .i_row_sel     (row_sel),
    .o_row         (o_c_row)
  );

  // pose prediction
  ekf_predict u_ekf_predict (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .i_pred_en (pred_en),
    .i_pose    (i_pose),
    .i_nl      (i_nl),
    .o_pred    (o_pred)
  );

endmodule

// ==== sim/tb_rsa.sv ====
`timescale 1ns/1ps
`include "rsa_consts.svh"

module tb_rsa;

  import rsa_pkg::*;

  localparam int MAX_K   = 12;
  localparam int TIMEOUT = 200;

  logic         clk;
  logic         sys_rst;
  stage_t       i_stage_val;
  pose_t        i_pose;
  nl_result_t   i_nl;
  op_beat_t     i_op;
  logic         i_op_valid;
  logic         i_op_last;
  stage_t       o_stage_rdy;
  predict_out_t o_pred;
  logic         o_c_valid;
  rsa_cnt_t     o_c_row_idx;
  c_row_t       o_c_row;

  // operands of the current multiply with A as X by K and B as K by Y
  rsa_data_t    a_m [`RSA_X][MAX_K];
  rsa_data_t    b_m [MAX_K][`RSA_Y];
  // expected results shared between stimulus and monitor
  c_row_t       exp_rows [`RSA_X];
  predict_out_t exp_pred;
  predict_out_t held_pred;
  string        test_name;
  bit           pred_armed;
  bit           pred_done;
  bit           mul_armed;
  bit           mul_done;
  bit           read_armed;
  int           rows_seen;
  bit           prev_valid;
  rsa_cnt_t     prev_idx;

  rsa_top dut (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .i_stage_val (i_stage_val),
    .i_pose      (i_pose),
    .i_nl        (i_nl),
    .i_op        (i_op),
    .i_op_valid  (i_op_valid),
    .i_op_last   (i_op_last),
    .o_stage_rdy (o_stage_rdy),
    .o_pred      (o_pred),
    .o_c_valid   (o_c_valid),
    .o_c_row_idx (o_c_row_idx),
    .o_c_row     (o_c_row)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // motion step where all sums wrap modulo 2^32
  function automatic predict_out_t ref_predict(pose_t pose, nl_result_t nl);
    predict_out_t r;
    r.pose_hat.x     = pose.x + nl.d_x;
    r.pose_hat.y     = pose.y + nl.d_y;
    r.pose_hat.theta = pose.theta + nl.d_theta;
    // jacobian terms are -dy and dx
    r.fxi_13         = rsa_data_t'(0) - nl.d_y;
    r.fxi_23         = nl.d_x;
    return r;
  endfunction

  // row r of A times B over k_len inner terms
  function automatic c_row_t ref_matmul(int r, int k_len);
    c_row_t    row;
    rsa_data_t sum;
    for (int c = 0; c < `RSA_Y; c++) begin
      sum = '0;
      for (int k = 0; k < k_len; k++) begin
        sum = sum + a_m[r][k] * b_m[k][c];
      end
      row[c] = sum;
    end
    return row;
  endfunction

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_pred(predict_out_t exp_v, predict_out_t act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("MISMATCH test=%s predict expected=%h actual=%h",
                         test_name, exp_v, act_v));
    end
  endtask

  task automatic check_row(c_row_t exp_v, c_row_t act_v, rsa_cnt_t idx);
    if (act_v !== exp_v) begin
      stop_run($sformatf("MISMATCH test=%s row %0d expected=%h actual=%h",
                         test_name, idx, exp_v, act_v));
    end
  endtask

  // compare process sampling at the falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (!sys_rst) begin
        if ($isunknown({o_stage_rdy, o_c_valid})) begin
          stop_run("handshake outputs are unknown after reset");
        end
        // readout rows come in order and back to back
        if (o_c_valid) begin
          if (!read_armed) begin
            stop_run("o_c_valid went high with no multiply in progress");
          end
          if (o_c_row_idx !== rsa_cnt_t'(rows_seen)) begin
            stop_run($sformatf("MISMATCH test=%s row index expected=%0d actual=%0d",
                               test_name, rows_seen, o_c_row_idx));
          end
          check_row(exp_rows[rows_seen], o_c_row, o_c_row_idx);
          rows_seen++;
          if (rows_seen == `RSA_X) begin
            read_armed = 1'b0;
          end
        end else if (read_armed && rows_seen != 0) begin
          stop_run("readout rows did not come on consecutive cycles");
        end
        // multiply ready right after row X-1
        if (o_stage_rdy[1]) begin
          if (!mul_armed || rows_seen != `RSA_X || !prev_valid ||
              prev_idx != rsa_cnt_t'(`RSA_X - 1)) begin
            stop_run("multiply ready pulse did not follow the last row");
          end
          mul_armed = 1'b0;
          mul_done  = 1'b1;
        end
        // predict result checked on the pulse, o_pred holds otherwise
        if (o_stage_rdy[0]) begin
          if (!pred_armed) begin
            stop_run("predict ready pulsed with no predict request");
          end
          check_pred(exp_pred, o_pred);
          held_pred  = o_pred;
          pred_armed = 1'b0;
          pred_done  = 1'b1;
        end else if (!pred_armed && o_pred !== held_pred) begin
          stop_run("o_pred changed without a predict stage");
        end
        prev_valid = o_c_valid;
        prev_idx   = o_c_row_idx;
      end
    end
  end

  // one predict stage with the request held for hold extra cycles
  task automatic run_predict(string name, pose_t pose, nl_result_t nl, int hold);
    int n;
    test_name  = name;
    exp_pred   = ref_predict(pose, nl);
    pred_done  = 1'b0;
    pred_armed = 1'b1;
    @(posedge clk);
    i_pose      <= pose;
    i_nl        <= nl;
    i_stage_val <= 2'b01;
    n = 0;
    while (!pred_done && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!pred_done) begin
      stop_run($sformatf("test %s timed out waiting for predict ready", name));
    end
    repeat (hold) @(posedge clk);
    i_stage_val <= '0;
  endtask

  // random operands for k_len inner terms
  task automatic fill_operands(int k_len);
    for (int k = 0; k < k_len; k++) begin
      for (int r = 0; r < `RSA_X; r++) begin
        a_m[r][k] = $urandom;
      end
      for (int c = 0; c < `RSA_Y; c++) begin
        b_m[k][c] = $urandom;
      end
    end
  endtask

  // one multiply stage with up to max_gap idle cycles before each beat
  task automatic run_matmul(string name, int k_len, int max_gap, int hold);
    int       n;
    int       gap;
    op_beat_t beat;
    test_name = name;
    for (int r = 0; r < `RSA_X; r++) begin
      exp_rows[r] = ref_matmul(r, k_len);
    end
    rows_seen  = 0;
    mul_done   = 1'b0;
    read_armed = 1'b1;
    mul_armed  = 1'b1;
    @(posedge clk);
    i_stage_val <= 2'b10;
    // pose inputs move while o_pred must not
    i_pose      <= {$urandom, $urandom, $urandom};
    i_nl        <= {$urandom, $urandom, $urandom};
    for (int k = 0; k < k_len; k++) begin
      gap = int'($urandom % (max_gap + 1));
      // junk with valid low is ignored
      repeat (gap) begin
        @(posedge clk);
        i_op       <= {8{$urandom}};
        i_op_valid <= 1'b0;
        i_op_last  <= 1'b1;
      end
      @(posedge clk);
      for (int r = 0; r < `RSA_X; r++) begin
        beat.a[r] = a_m[r][k];
      end
      for (int c = 0; c < `RSA_Y; c++) begin
        beat.b[c] = b_m[k][c];
      end
      i_op       <= beat;
      i_op_valid <= 1'b1;
      i_op_last  <= (k == k_len - 1);
    end
    @(posedge clk);
    i_op_valid <= 1'b0;
    i_op_last  <= 1'b0;
    n = 0;
    while (!mul_done && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!mul_done) begin
      stop_run($sformatf("test %s timed out waiting for multiply ready", name));
    end
    repeat (hold) @(posedge clk);
    i_stage_val <= '0;
  endtask

  initial begin
    pose_t      pose;
    nl_result_t nl;
    int         k_len;
    void'($urandom(31));
    sys_rst     = 1'b1;
    i_stage_val = '0;
    i_pose      = '0;
    i_nl        = '0;
    i_op        = '0;
    i_op_valid  = 1'b0;
    i_op_last   = 1'b0;
    held_pred   = '0;
    pred_armed  = 1'b0;
    pred_done   = 1'b0;
    mul_armed   = 1'b0;
    mul_done    = 1'b0;
    read_armed  = 1'b0;
    rows_seen   = 0;
    prev_valid  = 1'b0;
    prev_idx    = '0;
    test_name   = "reset";
    repeat (3) @(posedge clk);
    sys_rst <= 1'b0;

    // idle run where the monitor flags any stray pulse
    test_name = "idle";
    repeat (10) @(posedge clk);

    pose = {$urandom, $urandom, $urandom};
    nl   = {$urandom, $urandom, $urandom};
    run_predict("predict_random", pose, nl, 0);
    // forced wrap on every field
    pose.x       = 32'h7fffffff;
    pose.y       = 32'h80000000;
    pose.theta   = 32'hfffffff0;
    nl.d_x       = 32'sd1;
    nl.d_y       = 32'h80000000;
    nl.d_theta   = 32'sd32;
    run_predict("predict_wrap", pose, nl, 0);

    // identity times B gives B
    fill_operands(4);
    for (int r = 0; r < `RSA_X; r++) begin
      for (int k = 0; k < 4; k++) begin
        a_m[r][k] = (r == k) ? 32'sd1 : 32'sd0;
      end
    end
    run_matmul("matmul_identity", 4, 0, 0);

    // back to back random runs where stale sums would show
    for (int t = 0; t < 4; t++) begin
      k_len = 1 + int'($urandom % MAX_K);
      fill_operands(k_len);
      run_matmul($sformatf("matmul_random_%0d", t), k_len, 3, 0);
    end

    // requests held past the ready pulse
    pose = {$urandom, $urandom, $urandom};
    nl   = {$urandom, $urandom, $urandom};
    run_predict("predict_held", pose, nl, 6);
    k_len = 1 + int'($urandom % MAX_K);
    fill_operands(k_len);
    run_matmul("matmul_held", k_len, 2, 6);
    pose = {$urandom, $urandom, $urandom};
    nl   = {$urandom, $urandom, $urandom};
    run_predict("predict_after_hold", pose, nl, 0);
    fill_operands(5);
    run_matmul("matmul_after_hold", 5, 1, 0);

    repeat (5) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+source
source/rsa_pkg.sv
source/pe_mac.sv
source/pe_array.sv
source/ekf_predict.sv
source/stage_ctrl.sv
source/rsa_top.sv
sim/tb_rsa.sv

// ==== run.sh ====
#!/bin/sh
# build and run the systolic array testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_rsa -o tb_rsa_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/tb_rsa_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit $sim_status
fi

exit 0
